/* hw/exe_alu.sv */
/* Single-cycle RV64I ALU with one result register.
 * The result register only moves while advance_i is high.
 */
`timescale 1ns/1ps
`default_nettype none

`include "exe_config.svh"

module exe_alu (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               advance_i,
    input  logic               fire_i,
    input  exe_pkg::exe_issue_t issue_i,
    output exe_pkg::exe_wb_t    wb_o
);
    import exe_pkg::*;

    xlen_t       rs1;
    xlen_t       rs2;
    logic [5:0]  shamt;
    logic [4:0]  shamt_w;
    logic [31:0] res_w;   // low word of a W form.
    xlen_t       result;

    logic        valid_q;
    exe_wb_t     wb_q;

    assign rs1     = issue_i.data_rs1;
    assign rs2     = issue_i.data_rs2;
    assign shamt   = rs2[5:0];
    assign shamt_w = rs2[4:0];

    // sign-extends a 32-bit result to the full width.
    function automatic xlen_t sext_w(input logic [31:0] val);
        sext_w = {{(`EXE_XLEN-32){val[31]}}, val};
    endfunction

    // --------------------------------------------------
    // operation
    // --------------------------------------------------

    always_comb begin
        case (issue_i.op)
            OP_ADDW: res_w = rs1[31:0] + rs2[31:0];
            OP_SUBW: res_w = rs1[31:0] - rs2[31:0];
            OP_SLLW: res_w = rs1[31:0] << shamt_w;
            OP_SRLW: res_w = rs1[31:0] >> shamt_w;
            OP_SRAW: res_w = $signed(rs1[31:0]) >>> shamt_w;
            default: res_w = '0;
        endcase
    end

    always_comb begin
        case (issue_i.op)
            OP_ADD:  result = rs1 + rs2;
            OP_SUB:  result = rs1 - rs2;
            OP_SLL:  result = rs1 << shamt;
            OP_SLT:  result = {{(`EXE_XLEN-1){1'b0}}, $signed(rs1) < $signed(rs2)};
            OP_SLTU: result = {{(`EXE_XLEN-1){1'b0}}, rs1 < rs2};
            OP_XOR:  result = rs1 ^ rs2;
            OP_SRL:  result = rs1 >> shamt;
            OP_SRA:  result = $signed(rs1) >>> shamt;
            OP_OR:   result = rs1 | rs2;
            OP_AND:  result = rs1 & rs2;
            OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW: begin
                result = sext_w(res_w);
            end
            OP_PASS: result = rs1;
            default: result = '0;  // multiply opcodes never fire here.
        endcase
        // a SYSTEM op forwards rs1 whatever its opcode.
        if (issue_i.unit == UNIT_SYSTEM) begin
            result = rs1;
        end
    end

    // --------------------------------------------------
    // result register
    // --------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (advance_i) begin
            valid_q <= fire_i;  // an idle advance retires the old result.
        end
    end

    always_ff @(posedge clk_i) begin
        if (advance_i) begin
            wb_q.result     <= result;
            wb_q.rd         <= issue_i.rd;
            wb_q.regfile_we <= issue_i.regfile_we;
            wb_q.tag        <= issue_i.tag;
        end
    end

    assign wb_q.valid = valid_q;
    assign wb_o       = wb_q;

endmodule

`default_nettype wire

/* hw/exe_ctrl.sv */
/* Issue control for the execution stage.
 * Only one unit may finish per cycle; an ALU op waits when a multiply owns its slot.
 */
`timescale 1ns/1ps
`default_nettype none

`include "exe_config.svh"

module exe_ctrl (
    input  logic               clk_i,
    input  logic               rst_n_i,

    input  logic               issue_valid_i,
    input  exe_pkg::exe_issue_t issue_i,
    output logic               issue_ready_o,

    input  logic               wb_ready_i,
    input  exe_pkg::exe_wb_t    alu_wb_i,
    input  exe_pkg::exe_wb_t    mul_wb_i,
    output exe_pkg::exe_wb_t    wb_o,

    output logic               advance_o,
    output logic               alu_fire_o,
    output logic               mul_fire_o,
    output exe_pkg::exe_issue_t alu_issue_o,
    output exe_pkg::exe_issue_t mul_issue_o
);
    import exe_pkg::*;

    // one bit per future writeback slot; bit 0 is the slot opening on the next edge.
    localparam int RSV_W = `EXE_MUL_STAGES - 1;

    logic [RSV_W-1:0] slot_q, slot_d;
    logic             to_alu;
    logic             to_mul;
    logic             alu_blocked;
    logic             accept;

    // --------------------------------------------------
    // decode and handshake
    // --------------------------------------------------

    assign to_alu = (issue_i.unit == UNIT_ALU) || (issue_i.unit == UNIT_SYSTEM);
    assign to_mul = (issue_i.unit == UNIT_MUL);

    // the stage moves whenever the held writeback is taken or there is none.
    assign advance_o = wb_ready_i | ~wb_o.valid;

    assign alu_blocked   = to_alu & slot_q[0];  // a multiply finishes in that slot.
    assign issue_ready_o = advance_o & ~alu_blocked;
    assign accept        = issue_valid_i & issue_ready_o;

    assign alu_fire_o = accept & to_alu;
    assign mul_fire_o = accept & to_mul;  // UNIT_OTHER is accepted and dropped.

    // both datapaths see the same instruction; the fire strobes pick the owner.
    assign alu_issue_o = issue_i;
    assign mul_issue_o = issue_i;

    // --------------------------------------------------
    // slot reservation
    // --------------------------------------------------

    // a multiply accepted now finishes RSV_W edges after the one that takes it.
    always_comb begin
        slot_d            = slot_q >> 1;
        slot_d[RSV_W-1]   = mul_fire_o;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            slot_q <= '0;
        end else if (advance_o) begin
            slot_q <= slot_d;  // frozen together with the pipelines.
        end
    end

    // --------------------------------------------------
    // writeback select
    // --------------------------------------------------

    // The reservation keeps the two sources from being valid together,
    // so a priority pick is enough here.
    always_comb begin
        if (mul_wb_i.valid) begin
            wb_o = mul_wb_i;
        end else begin
            wb_o = alu_wb_i;  // carries valid low when the ALU is idle.
        end
    end

endmodule

`default_nettype wire

/* hw/exe_mul.sv */
/* Three-stage multiplier returning the low 64 bits of the product.
 * Signed and unsigned operands give the same low half, so no sign handling is needed.
 */
`timescale 1ns/1ps
`default_nettype none

`include "exe_config.svh"

module exe_mul (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               advance_i,
    input  logic               fire_i,
    input  exe_pkg::exe_issue_t issue_i,
    output exe_pkg::exe_wb_t    wb_o
);
    import exe_pkg::*;

    // writeback metadata that rides along with the operands.
    typedef struct packed {
        reg_addr_t rd;
        logic      regfile_we;
        tag_t      tag;
        logic      is_w;
    } mul_meta_t;

    logic        s1_valid_q, s2_valid_q, s3_valid_q;
    mul_meta_t   s1_meta_q, s2_meta_q;
    xlen_t       s1_a_q, s1_b_q;
    logic [31:0] pp_ll_lo_q, pp_ll_hi_q, pp_lh_q, pp_hl_q;
    logic [31:0] sum_hi;
    xlen_t       product;
    exe_wb_t     wb_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
            s3_valid_q <= 1'b0;
        end else if (advance_i) begin
            s1_valid_q <= fire_i;
            s2_valid_q <= s1_valid_q;
            s3_valid_q <= s2_valid_q;
        end
    end

    // --------------------------------------------------
    // datapath
    // --------------------------------------------------

    // stage 3 adds the cross terms into the upper word only.
    assign sum_hi  = pp_ll_hi_q + pp_lh_q + pp_hl_q;
    assign product = s2_meta_q.is_w ? {{(`EXE_XLEN-32){pp_ll_lo_q[31]}}, pp_ll_lo_q}
                                    : {sum_hi, pp_ll_lo_q};

    always_ff @(posedge clk_i) begin
        if (advance_i) begin
            s1_a_q              <= issue_i.data_rs1;  // stage 1.
            s1_b_q              <= issue_i.data_rs2;
            s1_meta_q.rd         <= issue_i.rd;
            s1_meta_q.regfile_we <= issue_i.regfile_we;
            s1_meta_q.tag        <= issue_i.tag;
            s1_meta_q.is_w       <= (issue_i.op == OP_MULW);
            {pp_ll_hi_q, pp_ll_lo_q} <= s1_a_q[31:0] * s1_b_q[31:0];  // stage 2.
            pp_lh_q    <= s1_a_q[31:0] * s1_b_q[63:32];  // only the low word counts.
            pp_hl_q    <= s1_a_q[63:32] * s1_b_q[31:0];
            s2_meta_q  <= s1_meta_q;
            wb_q.result     <= product;  // stage 3.
            wb_q.rd         <= s2_meta_q.rd;
            wb_q.regfile_we <= s2_meta_q.regfile_we;
            wb_q.tag        <= s2_meta_q.tag;
        end
    end

    assign wb_q.valid = s3_valid_q;
    assign wb_o       = wb_q;

endmodule

`default_nettype wire

/* hw/exe_pkg.sv */
/* Types shared by the execution stage and its testbench.
 * Opcode and unit encodings are local to this stage, not RISC-V encodings.
 */
`default_nettype none

`include "exe_config.svh"

package exe_pkg;

    // --------------------------------------------------
    // vectors with a meaning
    // --------------------------------------------------

    typedef logic [`EXE_XLEN-1:0]  xlen_t;      // operand or result.
    typedef logic [`EXE_REG_W-1:0] reg_addr_t;  // destination register.
    typedef logic [`EXE_TAG_W-1:0] tag_t;       // issue tag.

    // --------------------------------------------------
    // decoded operation
    // --------------------------------------------------

    // W forms work on the low word and sign-extend the result.
    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_SLL,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_SRL,
        OP_SRA,
        OP_OR,
        OP_AND,
        OP_ADDW,
        OP_SUBW,
        OP_SLLW,
        OP_SRLW,
        OP_SRAW,
        OP_MUL,
        OP_MULW,
        OP_PASS
    } exe_op_t;

    // functional unit chosen by the decoder.
    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_SYSTEM,
        UNIT_MUL,
        UNIT_OTHER
    } exe_unit_t;

    // --------------------------------------------------
    // stage interfaces
    // --------------------------------------------------

    // one issued instruction with its operands already read.
    typedef struct packed {
        exe_unit_t unit;
        exe_op_t   op;
        xlen_t     data_rs1;
        xlen_t     data_rs2;
        reg_addr_t rd;
        logic      regfile_we;
        tag_t      tag;
    } exe_issue_t;

    // one writeback to the register file.
    typedef struct packed {
        logic      valid;
        xlen_t     result;
        reg_addr_t rd;
        logic      regfile_we;
        tag_t      tag;
    } exe_wb_t;

endpackage

`default_nettype wire

/* hw/exe_top.sv */
/* Integer execution stage: control, ALU and multiplier.
 * Writebacks may leave out of issue order; match them by tag.
 */
`timescale 1ns/1ps
`default_nettype none

module exe_top (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               issue_valid_i,
    input  exe_pkg::exe_issue_t issue_i,
    output logic               issue_ready_o,
    output exe_pkg::exe_wb_t    wb_o,
    input  logic               wb_ready_i
);
    import exe_pkg::*;

    logic       advance;
    logic       alu_fire;
    logic       mul_fire;
    exe_issue_t alu_issue;
    exe_issue_t mul_issue;
    exe_wb_t    alu_wb;
    exe_wb_t    mul_wb;

    exe_ctrl u_ctrl (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .issue_ready_o (issue_ready_o),
        .wb_ready_i    (wb_ready_i),
        .alu_wb_i      (alu_wb),
        .mul_wb_i      (mul_wb),
        .wb_o          (wb_o),
        .advance_o     (advance),
        .alu_fire_o    (alu_fire),
        .mul_fire_o    (mul_fire),
        .alu_issue_o   (alu_issue),
        .mul_issue_o   (mul_issue)
    );

    exe_alu u_alu (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .advance_i (advance),
        .fire_i    (alu_fire),
        .issue_i   (alu_issue),
        .wb_o      (alu_wb)
    );

    exe_mul u_mul (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .advance_i (advance),
        .fire_i    (mul_fire),
        .issue_i   (mul_issue),
        .wb_o      (mul_wb)
    );

endmodule

`default_nettype wire

/* include/exe_config.svh */
/* Sizing macros for the execution stage.
 * EXE_MUL_STAGES must stay at 3, the depth built into exe_mul.
 */
`ifndef EXE_CONFIG_SVH
`define EXE_CONFIG_SVH

// --------------------------------------------------
// datapath widths
// --------------------------------------------------

// operand and result width in bits.
`define EXE_XLEN 64

// architectural register address width.
`define EXE_REG_W 5

// issue tag width, enough for 16 instructions in flight.
`define EXE_TAG_W 4

// --------------------------------------------------
// latencies
// --------------------------------------------------

`define EXE_MUL_STAGES 3  // cycles from issue to writeback for MUL and MULW.

`endif

/* run.sh */
#!/usr/bin/env bash
# Builds the execution stage testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module exe_tb -Mdir obj_dir -f verilog.f

# keep running after an assertion error so the closing summary still prints.
output=$(./obj_dir/Vexe_tb +verilator+error+limit+1000 2>&1) || true
echo "$output"

if grep -q "PASS: all tests" <<< "$output"; then
    exit 0
fi
exit 1

/* verif/exe_chk.sv */
/* Protocol assertions for the writeback port of exe_top.
 * Bound to every exe_top instance.
 */
`timescale 1ns/1ps
`default_nettype none

module exe_chk (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             issue_ready_i,
    input  logic             wb_ready_i,
    input  exe_pkg::exe_wb_t wb_i
);
    import exe_pkg::*;

    int fail_count = 0;  // assertions that have failed so far.

    // --------------------------------------------------
    // writeback port rules
    // --------------------------------------------------

    // the result registers are cleared while reset is held.
    reset_quiet: assert property (@(negedge clk_i) !rst_n_i |-> !wb_i.valid)
        else begin
            fail_count++;
            $error("writeback valid while reset is held");
        end

    hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (wb_i.valid && !wb_ready_i) |=> $stable(wb_i))
        else begin
            fail_count++;
            $error("writeback changed while it was stalled");
        end

    // a stalled writeback freezes the stage, so nothing new may enter.
    stall_blocks_issue: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (wb_i.valid && !wb_ready_i) |-> !issue_ready_i)
        else begin
            fail_count++;
            $error("issue ready while the writeback was stalled");
        end

endmodule

bind exe_top exe_chk u_chk (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .issue_ready_i (issue_ready_o),
    .wb_ready_i    (wb_ready_i),
    .wb_i          (wb_o)
);

`default_nettype wire

/* verif/exe_tb.sv */
/* Self-checking testbench for exe_top. Writebacks are matched to issues by tag,
 * so no more than 16 instructions may be in flight at once.
 */
`timescale 1ns/1ps
`default_nettype none

`include "exe_config.svh"

module exe_tb;
    import exe_pkg::*;

    logic       clk, rst_n, issue_valid, issue_ready, wb_ready;
    exe_issue_t issue;
    exe_wb_t    wb;

    logic [63:0] rng = 64'd22;     // operand stream.
    logic [63:0] bp_rng = 64'd22;  // back-pressure stream.
    logic        bp_on = 1'b0;
    logic        lat_check = 1'b1;
    tag_t        next_tag = '0;

    // --------------------------------------------------
    // expected results by tag
    // --------------------------------------------------
    xlen_t     exp_res [16];
    reg_addr_t exp_rd [16];
    bit        exp_we [16];
    int        acc_cyc [16];
    int        exp_lat [16];
    bit        pending [16];
    bit        dropped [16];
    int        cyc = 0;
    int        inflight = 0;
    int        errors = 0;
    int        errs_at_start = 0;
    int        tests = 0;
    int        failed = 0;
    string     test_name = "reset";

    exe_top dut_i (
        .clk_i (clk), .rst_n_i (rst_n), .issue_valid_i (issue_valid), .issue_i (issue),
        .issue_ready_o (issue_ready), .wb_o (wb), .wb_ready_i (wb_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [63:0] xorshift(input logic [63:0] s);
        logic [63:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 7);
        return x ^ (x << 17);
    endfunction

    function automatic xlen_t rand64();
        rng = xorshift(rng);
        return rng;
    endfunction

    // reference results, straight from the RV64I definitions.
    function automatic xlen_t model(input exe_issue_t t);
        xlen_t       a, b;
        logic [31:0] lo;
        a = t.data_rs1;
        b = t.data_rs2;
        if (t.unit == UNIT_SYSTEM) return a;
        case (t.op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_SLL:  return a << b[5:0];
            OP_SLT:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            OP_SLTU: return (a < b) ? 64'd1 : 64'd0;
            OP_XOR:  return a ^ b;
            OP_SRL:  return a >> b[5:0];
            OP_SRA:  return $signed(a) >>> b[5:0];
            OP_OR:   return a | b;
            OP_AND:  return a & b;
            OP_MUL:  return a * b;
            OP_ADDW: lo = a[31:0] + b[31:0];
            OP_SUBW: lo = a[31:0] - b[31:0];
            OP_SLLW: lo = a[31:0] << b[4:0];
            OP_SRLW: lo = a[31:0] >> b[4:0];
            OP_SRAW: lo = $signed(a[31:0]) >>> b[4:0];
            OP_MULW: lo = a[31:0] * b[31:0];
            default: return a;  // PASS.
        endcase
        return {{32{lo[31]}}, lo};  // W forms.
    endfunction

    function automatic int error_total();
        return errors + dut_i.u_chk.fail_count;
    endfunction

    task automatic note_mismatch(input string what, input logic [63:0] exp,
                                 input logic [63:0] act);
        $display("error %s: %s expected %0h, actual %0h", test_name, what, exp, act);
        errors++;
    endtask

    task automatic report_fault(input string text);
        $display("test %s: %s", test_name, text);
        errors++;
    endtask

    // --------------------------------------------------
    // monitor, sampled mid-cycle where every output has settled
    // --------------------------------------------------
    task automatic check_writeback();
        tag_t t;
        t = wb.tag;
        assert (!dropped[t]) else report_fault($sformatf("dropped tag %0d wrote back", t));
        assert (pending[t]) else report_fault($sformatf("tag %0d wrote back but was not issued", t));
        if (pending[t]) begin
            assert (wb.result == exp_res[t])
                else note_mismatch($sformatf("result of tag %0d", t), exp_res[t], wb.result);
            assert (wb.rd == exp_rd[t])
                else note_mismatch($sformatf("rd of tag %0d", t), exp_rd[t], wb.rd);
            assert (wb.regfile_we == exp_we[t])
                else note_mismatch($sformatf("regfile_we of tag %0d", t), exp_we[t],
                                   wb.regfile_we);
            if (lat_check) begin
                assert (cyc - acc_cyc[t] == exp_lat[t])
                    else note_mismatch($sformatf("latency of tag %0d", t), exp_lat[t],
                                       cyc - acc_cyc[t]);
            end
            pending[t] = 1'b0;
            inflight--;
        end
    endtask

    always @(negedge clk) begin
        cyc = cyc + 1;
        if (rst_n && issue_valid && issue_ready) begin
            dropped[issue.tag] = (issue.unit == UNIT_OTHER);
            if (issue.unit != UNIT_OTHER) begin
                pending[issue.tag] = 1'b1;
                exp_res[issue.tag] = model(issue);
                exp_rd[issue.tag]  = issue.rd;
                exp_we[issue.tag]  = issue.regfile_we;
                acc_cyc[issue.tag] = cyc;
                exp_lat[issue.tag] = (issue.unit == UNIT_MUL) ? `EXE_MUL_STAGES : 1;
                inflight++;
            end
        end
        if (rst_n && wb.valid && wb_ready) check_writeback();
    end

    always @(posedge clk) begin
        if (bp_on) begin
            bp_rng = xorshift(bp_rng);
            wb_ready <= bp_rng[7];
        end else begin
            wb_ready <= 1'b1;
        end
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    task automatic send(input exe_unit_t unit_sel, input exe_op_t op_sel, input xlen_t a,
                        input xlen_t b);
        int    waited;
        xlen_t r;
        r = rand64();
        issue_valid <= 1'b1;
        issue <= '{unit: unit_sel, op: op_sel, data_rs1: a, data_rs2: b, rd: r[4:0],
                   regfile_we: r[5], tag: next_tag};
        waited = 0;
        @(negedge clk);
        while (!issue_ready && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        if (!issue_ready) report_fault("the stage refused an issue for 100 cycles");
        @(posedge clk);
        issue_valid <= 1'b0;
        next_tag++;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (inflight != 0 && waited < 200) begin
            @(posedge clk);
            waited++;
        end
        if (inflight != 0) report_fault($sformatf("%0d results never came back", inflight));
    endtask

    task automatic start_test(input string name);
        test_name = name;
        errs_at_start = error_total();
    endtask

    task automatic finish_test();
        tests++;
        if (error_total() == errs_at_start) begin
            $display("test %s: passed", test_name);
        end else begin
            $display("test %s: failed with %0d errors", test_name, error_total() - errs_at_start);
            failed++;
        end
    endtask

    task automatic mixed_stream(input int count);
        xlen_t r;
        for (int i = 0; i < count; i++) begin
            r = rand64();
            if (r[0]) send(UNIT_MUL, r[1] ? OP_MULW : OP_MUL, rand64(), rand64());
            else send(UNIT_ALU, exe_op_t'(r[8:4] % 5'd15), rand64(), rand64());
        end
    endtask

    initial begin
        xlen_t a;
        rst_n = 1'b0;
        issue_valid = 1'b0;
        issue = '0;
        wb_ready = 1'b1;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        start_test("reset_state");
        @(negedge clk);
        assert (!wb.valid) else note_mismatch("wb valid", 0, wb.valid);
        assert (issue_ready) else note_mismatch("issue ready", 1, issue_ready);
        @(posedge clk);
        finish_test();

        start_test("alu_ops");
        for (int i = 0; i < 15; i++) begin
            send(UNIT_ALU, exe_op_t'(i[4:0]), rand64(), rand64());
            send(UNIT_ALU, exe_op_t'(i[4:0]), rand64(), rand64() | 64'h3f);  // shift by 63 or 31.
        end
        drain();
        finish_test();

        start_test("mul_ops");
        for (int i = 0; i < 12; i++) begin
            a = rand64();
            if (i % 3 != 0) a = a | 64'h8000_0000_8000_0000;  // negative in both widths.
            send(UNIT_MUL, i[0] ? OP_MULW : OP_MUL, a, rand64());
        end
        drain();
        finish_test();

        start_test("mixed_order");
        mixed_stream(32);
        drain();
        finish_test();

        start_test("backpressure");
        lat_check = 1'b0;
        bp_on <= 1'b1;
        mixed_stream(40);
        drain();
        bp_on <= 1'b0;
        finish_test();

        start_test("pass_and_drop");
        send(UNIT_SYSTEM, OP_PASS, rand64(), rand64());
        send(UNIT_SYSTEM, OP_XOR, rand64(), rand64());
        send(UNIT_OTHER, OP_ADD, rand64(), rand64());
        drain();
        repeat (30) @(posedge clk);  // the dropped tag must stay silent this long.
        finish_test();

        $display("tests run: %0d, failed: %0d, errors: %0d", tests, failed, error_total());
        if (error_total() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
hw/exe_pkg.sv
hw/exe_alu.sv
hw/exe_mul.sv
hw/exe_ctrl.sv
hw/exe_top.sv
verif/exe_chk.sv
verif/exe_tb.sv
